/* Makefile */
# Verilator lint and simulation for the data cache subsystem

VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/100ps
TB_TOP    ?= dcache_top_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/dcache_top_tb.sv */
/*
  Testbench for the data cache top, one table row per request.
  A row with grp set starts in the same cycle as the row after it,
  rows of a group must be listed in port order.
*/
`default_nettype none

module dcache_top_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dcache_pkg::*;

  localparam logic [31:0] PRELOAD_XOR  = 32'hA5A5_0000;
  localparam int unsigned SEED         = 32'h5d4465c3;
  localparam int          NUM_ROWS     = 19;
  localparam int          RESET_CYCLES = 16;
  // 40 cycles of 10 ns per row, plus reset
  localparam int          TIMEOUT_NS   = 10 * (RESET_CYCLES + NUM_ROWS * 40);

  typedef struct {
    int          port;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        en;
    logic        fl;
    logic        grp;
    logic [31:0] exp_data;
    logic        exp_miss;
    int          exp_cyc;
  } row_t;

  logic clk = 1'b0;
  logic arst_n;
  logic enable;
  logic flush;
  logic flush_ack;
  logic miss;
  logic [NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0] we;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] addr;
  logic [NUM_PORTS-1:0][DATA_W-1:0] wdata;
  logic [NUM_PORTS-1:0][BE_W-1:0] be;
  logic [NUM_PORTS-1:0] gnt;
  logic [NUM_PORTS-1:0] rvalid;
  logic [NUM_PORTS-1:0][DATA_W-1:0] rdata;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0] wb_dat;
  logic [DATA_W-1:0] wb_rdat;
  logic [BE_W-1:0] wb_sel;
  logic wb_ack;

  row_t        rows [NUM_ROWS];
  // reference memory, written words only
  logic [31:0] ref_mem [logic [29:0]];
  logic        cyc_seen = 1'b0;
  int          checks = 0;
  int          errors = 0;

  always #5 clk = ~clk;

  dcache_top dcache_top_i (
    .clk_i (clk), .arst_n_i (arst_n), .enable_i (enable), .flush_i (flush),
    .flush_ack_o (flush_ack), .miss_o (miss),
    .req_i (req), .we_i (we), .addr_i (addr), .wdata_i (wdata), .be_i (be),
    .gnt_o (gnt), .rvalid_o (rvalid), .rdata_o (rdata),
    .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
    .wb_dat_o (wb_dat), .wb_sel_o (wb_sel), .wb_dat_i (wb_rdat), .wb_ack_i (wb_ack)
  );

  wb_mem_model #(.PRELOAD_XOR(PRELOAD_XOR)) wb_mem_model_i (
    .clk_i (clk), .arst_n_i (arst_n), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_we_i (wb_we), .wb_adr_i (wb_adr), .wb_dat_i (wb_dat), .wb_sel_i (wb_sel),
    .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack)
  );

  // ----------------------------------------
  // checks and reference model
  // ----------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s at %0t", what, $time);
    end
  endtask

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    if (ref_mem.exists(a[31:2])) begin
      return ref_mem[a[31:2]];
    end
    return {a[31:2], 2'b00} ^ PRELOAD_XOR;
  endfunction

  function automatic row_t make_row(input int port, input logic w, input logic [31:0] a,
                                    input logic [31:0] d, input logic [3:0] b,
                                    input logic en, input logic fl, input logic grp);
    row_t row;
    row = '{port, w, a, d, b, en, fl, grp, 32'h0, 1'b0, 0};
    return row;
  endfunction

  // stimulus, then expected data, miss and bus cycles in request order
  task automatic build_table();
    logic [NUM_LINES-1:0] ref_valid;
    logic [TAG_W-1:0]     ref_tag [NUM_LINES];
    logic [INDEX_W-1:0]   idx;
    logic                 hit;
    logic [31:0]          word;
    rows[0]  = make_row(1, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[1]  = make_row(1, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[2]  = make_row(2, 1'b1, 32'h0000_0100, 32'h1122_3344, 4'b0101, 1'b1, 1'b0, 1'b0);
    rows[3]  = make_row(1, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[4]  = make_row(2, 1'b1, 32'h0000_0204, 32'hdead_beef, 4'hf, 1'b1, 1'b0, 1'b0);
    rows[5]  = make_row(1, 1'b0, 32'h0000_0204, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    // all three ports in one cycle
    rows[6]  = make_row(0, 1'b0, 32'h0000_0308, 32'h0, 4'h0, 1'b1, 1'b0, 1'b1);
    rows[7]  = make_row(1, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b1, 1'b0, 1'b1);
    rows[8]  = make_row(2, 1'b0, 32'h0000_0310, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    // same index 8, evict each other
    rows[9]  = make_row(1, 1'b0, 32'h0000_0420, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[10] = make_row(1, 1'b0, 32'h0000_0820, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[11] = make_row(1, 1'b0, 32'h0000_0420, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[12] = make_row(1, 1'b0, 32'h0000_0820, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    // flush with a read waiting behind it
    rows[13] = make_row(1, 1'b0, 32'h0000_0820, 32'h0, 4'h0, 1'b1, 1'b1, 1'b0);
    rows[14] = make_row(0, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[15] = make_row(1, 1'b0, 32'h0000_0500, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
    rows[16] = make_row(1, 1'b0, 32'h0000_0500, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
    rows[17] = make_row(1, 1'b0, 32'h0000_0500, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    rows[18] = make_row(1, 1'b0, 32'h0000_0500, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
    ref_valid = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      idx = rows[r].addr[INDEX_W+1:2];
      if (rows[r].fl) begin
        ref_valid = '0;
      end
      hit  = ref_valid[idx] && (ref_tag[idx] == rows[r].addr[ADDR_W-1:INDEX_W+2]);
      word = ref_read(rows[r].addr);
      if (rows[r].we) begin
        // write through, always one bus write
        for (int b = 0; b < BE_W; b++) begin
          if (rows[r].be[b]) begin
            word[8*b +: 8] = rows[r].wdata[8*b +: 8];
          end
        end
        ref_mem[rows[r].addr[31:2]] = word;
        rows[r].exp_cyc = 1;
      end else begin
        rows[r].exp_data = word;
        rows[r].exp_miss = rows[r].en && !hit;
        rows[r].exp_cyc  = (rows[r].en && hit) ? 0 : 1;
        if (rows[r].exp_miss) begin
          ref_valid[idx] = 1'b1;
          ref_tag[idx]   = rows[r].addr[ADDR_W-1:INDEX_W+2];
        end
      end
    end
  endtask

  // ----------------------------------------
  // one group of rows
  // ----------------------------------------
  // drive at the falling edge, sample at the rising edge
  task automatic run_group(input int first, input int last);
    int                   row_of [NUM_PORTS];
    int                   gnt_at [NUM_PORTS];
    logic [NUM_PORTS-1:0] drop;
    logic                 fl_done;
    logic                 bus_on;
    int                   n;
    int                   nxt;
    int                   cur;
    int                   left;
    int                   ack_at;
    int                   cyc_at;
    int                   starts;
    int                   want_cyc;
    int                   r;
    n        = 0;
    nxt      = first;
    cur      = first;
    left     = last - first + 1;
    ack_at   = 0;
    cyc_at   = 0;
    starts   = 0;
    want_cyc = 0;
    drop     = '0;
    fl_done  = 1'b0;
    bus_on   = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      row_of[q] = -1;
      gnt_at[q] = 0;
    end
    @(negedge clk);
    enable = rows[first].en;
    flush  = rows[first].fl;
    for (int i = first; i <= last; i++) begin
      row_of[rows[i].port] = i;
      req[rows[i].port]    = 1'b1;
      we[rows[i].port]     = rows[i].we;
      addr[rows[i].port]   = rows[i].addr;
      wdata[rows[i].port]  = rows[i].wdata;
      be[rows[i].port]     = rows[i].be;
      want_cyc += rows[i].exp_cyc;
    end
    while (left > 0 || flush) begin
      @(posedge clk);
      n++;
      // mem_req the cycle after gnt, cyc and stb one cycle later
      if (n == cyc_at) begin
        bus_on = 1'b1;
      end
      check_true(gnt == '0 || !flush, "grant given during the flush walk");
      check_true(gnt != '0 || !miss, "miss pulse without a grant");
      check_val("wb_cyc_o", 32'(wb_cyc), 32'(bus_on));
      check_val("wb_stb_o", 32'(wb_stb), 32'(bus_on));
      if (flush_ack) begin
        check_true(flush, "flush ack with no flush requested");
        // flush taken in the first cycle, 16 lines cleared, then the ack
        check_val("flush_ack_o cycle", n, 18);
        fl_done = 1'b1;
      end
      if (gnt != '0) begin
        if (nxt > last) begin
          check_true(1'b0, "grant with no request waiting");
        end else begin
          check_val("gnt_o", 32'(gnt), 32'(1) << rows[nxt].port);
          check_val("miss_o", 32'(miss), 32'(rows[nxt].exp_miss));
          gnt_at[rows[nxt].port] = n;
          if (rows[nxt].exp_cyc != 0) begin
            cyc_at = n + 2;
          end
          cur = nxt;
          nxt++;
        end
      end
      if (wb_cyc && !cyc_seen) begin
        starts++;
      end
      cyc_seen = wb_cyc;
      if (wb_cyc && wb_ack) begin
        ack_at = n;
        // bus cycle ends in the cycle after ack
        bus_on = 1'b0;
        check_val("wb_we_o", 32'(wb_we), 32'(rows[cur].we));
        check_val("wb_adr_o", wb_adr, {rows[cur].addr[31:2], 2'b00});
        if (rows[cur].we) begin
          check_val("wb_sel_o", 32'(wb_sel), 32'(rows[cur].be));
          check_val("wb_dat_o", wb_dat, rows[cur].wdata);
          left--;
        end
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (rvalid[q]) begin
          r = row_of[q];
          if (r < 0 || rows[r].we || gnt_at[q] == 0) begin
            check_true(1'b0, "read data on a port with no read waiting");
          end else begin
            check_val("rdata_o", rdata[q], rows[r].exp_data);
            // hit one cycle after gnt, else one cycle after ack
            check_val("rvalid_o cycle", n,
                      (rows[r].exp_cyc == 0) ? gnt_at[q] + 1 : ack_at + 1);
            row_of[q] = -1;
            left--;
          end
        end
      end
      drop = gnt;
      @(negedge clk);
      req = req & ~drop;
      if (fl_done) begin
        flush   = 1'b0;
        fl_done = 1'b0;
      end
    end
    check_val("wb cycle count", starts, want_cyc);
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    int r;
    int first;
    void'($urandom(SEED));
    arst_n = 1'b0;
    enable = 1'b1;
    flush  = 1'b0;
    req    = '0;
    we     = '0;
    addr   = '0;
    wdata  = '0;
    be     = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_true(gnt == '0 && rvalid == '0 && !miss && !flush_ack && !wb_cyc && !wb_stb,
               "outputs not idle after reset");
    r = 0;
    while (r < NUM_ROWS) begin
      first = r;
      while (rows[r].grp) begin
        r++;
      end
      run_group(first, r);
      r++;
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, a request got no grant, response or flush ack in time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/wb_mem_model.sv */
/*
  Wishbone classic slave memory for the cache testbench.
  Unwritten words read as address XOR PRELOAD_XOR, writes honour wb_sel_i.
  Ack comes 2 to 5 cycles after stb rises, a random extra wait of 0 to 3.
*/
`default_nettype none

module wb_mem_model #(
  parameter logic [31:0] PRELOAD_XOR = 32'h0
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // written words only, keyed by word address
  logic [31:0] store_q [logic [29:0]];
  logic        busy_q;
  logic [1:0]  wait_q;

  function automatic logic [31:0] read_word(input logic [29:0] waddr);
    if (store_q.exists(waddr)) begin
      return store_q[waddr];
    end
    return {waddr, 2'b00} ^ PRELOAD_XOR;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  sel);
    logic [31:0] word;
    word = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        word[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return word;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      wait_q   <= 2'd0;
      wb_ack_o <= 1'b0;
      wb_dat_o <= 32'h0;
    end else begin
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy_q) begin
          // new cycle, draw the wait
          busy_q <= 1'b1;
          wait_q <= 2'($urandom % 4);
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q   <= 1'b0;
          wb_ack_o <= 1'b1;
          wb_dat_o <= read_word(wb_adr_i[31:2]);
          if (wb_we_i) begin
            store_q[wb_adr_i[31:2]] = merge_word(read_word(wb_adr_i[31:2]), wb_dat_i, wb_sel_i);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dcache_top.f */
design/dcache_pkg.sv
design/dcache_port_arbiter.sv
design/dcache_ctrl.sv
design/dcache_mem_if.sv
design/dcache_top.sv
bench/wb_mem_model.sv
bench/dcache_top_tb.sv

/* design/dcache_ctrl.sv */
/*
  Direct-mapped write-through cache controller, no write allocate.
  Handles one request at a time; flush_i wins over a waiting request.
  Writes always go to memory and update the line only on a tag hit.
*/
`default_nettype none

module dcache_ctrl (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  input  logic                          flush_i,
  output logic                          flush_ack_o,
  output logic                          miss_o,
  // request from the arbiter
  input  logic                          sel_req_i,
  input  logic                          sel_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0] sel_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0] sel_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]   sel_be_i,
  input  logic [dcache_pkg::PORT_W-1:0] sel_port_i,
  output logic                          accept_o,
  output logic                          resp_valid_o,
  output logic [dcache_pkg::PORT_W-1:0] resp_port_o,
  output logic [dcache_pkg::DATA_W-1:0] resp_data_o,
  // memory operation towards the bus master
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
  output logic [dcache_pkg::BE_W-1:0]   mem_be_o,
  input  logic                          mem_done_i,
  input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i
);
  import dcache_pkg::*;

  // ----------------------------------------
  // storage
  // ----------------------------------------
  logic [TAG_W-1:0]     tag_q  [NUM_LINES];
  logic [DATA_W-1:0]    data_q [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;

  ctrl_state_t          state_q;
  logic [INDEX_W-1:0]   flush_idx_q;

  // latched request
  logic                 we_q;
  logic [PORT_W-1:0]    port_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [DATA_W-1:0]    wdata_q;
  logic [BE_W-1:0]      be_q;
  // fill line on return / merge bytes on write completion
  logic                 fill_q;
  logic                 upd_q;

  logic [INDEX_W-1:0]   sel_idx;
  logic [TAG_W-1:0]     sel_tag;
  logic [INDEX_W-1:0]   req_idx;
  logic [TAG_W-1:0]     req_tag;
  logic                 tag_match;
  logic                 read_hit;
  logic                 mem_fin;

  assign sel_idx = sel_addr_i[INDEX_W+1:2];
  assign sel_tag = sel_addr_i[ADDR_W-1:INDEX_W+2];
  assign req_idx = addr_q[INDEX_W+1:2];
  assign req_tag = addr_q[ADDR_W-1:INDEX_W+2];

  // tag match ignores enable so writes keep a valid line coherent
  assign tag_match = valid_q[sel_idx] && (tag_q[sel_idx] == sel_tag);
  // reads are only served from the array with the cache enabled
  assign read_hit  = enable_i && tag_match && !sel_we_i;

  // take a request only in IDLE and never over a pending flush
  assign accept_o = (state_q == IDLE) && sel_req_i && !flush_i;
  // perf pulse, in the grant cycle of a cached read miss
  assign miss_o   = accept_o && !sel_we_i && enable_i && !tag_match;
  assign mem_fin  = (state_q == MEM_WAIT) && mem_done_i;

  // ----------------------------------------
  // control FSM and valid bits
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      valid_q     <= '0;
      flush_idx_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (flush_i) begin
            state_q     <= FLUSH;
            flush_idx_q <= '0;
          end else if (accept_o) begin
            state_q <= read_hit ? HIT_RESP : MEM_WAIT;
          end
        end
        HIT_RESP: state_q <= IDLE;
        MEM_WAIT: begin
          if (mem_done_i) begin
            if (fill_q) begin
              valid_q[req_idx] <= 1'b1;
            end
            state_q <= IDLE;
          end
        end
        FLUSH: begin
          // walk every index, one line per cycle
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == INDEX_W'(NUM_LINES - 1)) begin
            state_q <= FLUSH_ACK;
          end
        end
        FLUSH_ACK: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // request latch, tag and data arrays
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      we_q    <= sel_we_i;
      port_q  <= sel_port_i;
      addr_q  <= sel_addr_i;
      wdata_q <= sel_wdata_i;
      be_q    <= sel_be_i;
      // disabled reads bypass the array entirely
      fill_q  <= enable_i && !sel_we_i;
      upd_q   <= sel_we_i && tag_match;
    end
    if (mem_fin) begin
      if (fill_q) begin
        tag_q[req_idx]  <= req_tag;
        data_q[req_idx] <= mem_rdata_i;
      end
      // byte merge on a write hit
      for (int b = 0; b < BE_W; b++) begin
        if (upd_q && be_q[b]) begin
          data_q[req_idx][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  // hit data straight from the array, array is untouched in HIT_RESP
  assign resp_valid_o = (state_q == HIT_RESP) || (mem_fin && !we_q);
  assign resp_port_o  = port_q;
  assign resp_data_o  = (state_q == HIT_RESP) ? data_q[req_idx] : mem_rdata_i;
  assign flush_ack_o  = (state_q == FLUSH_ACK);

  // operation fields are held for the whole of MEM_WAIT
  assign mem_req_o   = (state_q == MEM_WAIT);
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign mem_be_o    = be_q;

endmodule

`default_nettype wire

/* design/dcache_mem_if.sv */
/*
  Wishbone classic master, one single-word cycle per memory operation.
  Operation fields must stay stable while mem_req_i is high.
*/
`default_nettype none

module dcache_mem_if (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // operation from the controller
  input  logic                          mem_req_i,
  input  logic                          mem_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [dcache_pkg::DATA_W-1:0] mem_wdata_i,
  input  logic [dcache_pkg::BE_W-1:0]   mem_be_i,
  output logic                          mem_done_o,
  output logic [dcache_pkg::DATA_W-1:0] mem_rdata_o,
  // Wishbone classic
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] wb_adr_o,
  output logic [dcache_pkg::DATA_W-1:0] wb_dat_o,
  output logic [dcache_pkg::BE_W-1:0]   wb_sel_o,
  input  logic [dcache_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i
);
  import dcache_pkg::*;

  // cyc_q is the state, idle or in a bus cycle
  logic              cyc_q;
  logic              done_q;
  // req still high from the finished op, do not restart
  logic              wait_low_q;
  logic [DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q      <= 1'b0;
      done_q     <= 1'b0;
      wait_low_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!mem_req_i) begin
        wait_low_q <= 1'b0;
      end
      if (cyc_q) begin
        // cycle ends the clock after ack
        if (wb_ack_i) begin
          cyc_q      <= 1'b0;
          done_q     <= 1'b1;
          wait_low_q <= 1'b1;
        end
      end else if (mem_req_i && !wait_low_q) begin
        cyc_q <= 1'b1;
      end
    end
  end

  // read data captured on ack, valid with mem_done
  always_ff @(posedge clk_i) begin
    if (cyc_q && wb_ack_i) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;

  // ----------------------------------------
  // bus drive
  // ----------------------------------------
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = mem_we_i;
  // word aligned, byte lanes go on sel
  assign wb_adr_o = {mem_addr_i[ADDR_W-1:2], 2'b00};
  assign wb_dat_o = mem_wdata_i;
  assign wb_sel_o = mem_be_i;

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
/*
  Shared widths and controller states for the direct-mapped data cache.
  One word per line; the index sits just above the byte offset.
*/
`default_nettype none

package dcache_pkg;

  // ----------------------------------------
  // word and address geometry
  // ----------------------------------------
  // byte address, word aligned on the bus side
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // one enable per byte lane
  localparam int unsigned BE_W = DATA_W / 8;

  // ----------------------------------------
  // request ports
  // ----------------------------------------
  // 0 page walker, 1 load unit, 2 store unit
  localparam int unsigned NUM_PORTS = 3;
  localparam int unsigned PORT_W = 2;

  // ----------------------------------------
  // cache organisation
  // ----------------------------------------
  // index is addr[5:2], 16 lines of one word
  localparam int unsigned INDEX_W = 4;
  localparam int unsigned NUM_LINES = 1 << INDEX_W;
  // whatever is left above index and byte offset
  localparam int unsigned TAG_W = ADDR_W - INDEX_W - 2;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    // read hit, response goes out this cycle
    HIT_RESP,
    // miss, uncached read or write on the bus
    MEM_WAIT,
    // one line cleared per cycle
    FLUSH,
    FLUSH_ACK
  } ctrl_state_t;

endpackage

`default_nettype wire

/* design/dcache_port_arbiter.sv */
/*
  Fixed-priority request arbiter, port 0 wins.
  Once a port is shown to the controller it stays selected until granted,
  so requesters must hold req and fields stable until gnt.
*/
`default_nettype none

module dcache_port_arbiter (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // request ports
  input  logic [dcache_pkg::NUM_PORTS-1:0]                   req_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0]                   we_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::DATA_W-1:0] wdata_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::BE_W-1:0]   be_i,
  output logic [dcache_pkg::NUM_PORTS-1:0]                   gnt_o,
  output logic [dcache_pkg::NUM_PORTS-1:0]                   rvalid_o,
  output logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::DATA_W-1:0] rdata_o,
  // selected request towards the controller
  output logic                                               sel_req_o,
  output logic                                               sel_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]                      sel_addr_o,
  output logic [dcache_pkg::DATA_W-1:0]                      sel_wdata_o,
  output logic [dcache_pkg::BE_W-1:0]                        sel_be_o,
  output logic [dcache_pkg::PORT_W-1:0]                      sel_port_o,
  // controller handshake and response
  input  logic                                               accept_i,
  input  logic                                               resp_valid_i,
  input  logic [dcache_pkg::PORT_W-1:0]                      resp_port_i,
  input  logic [dcache_pkg::DATA_W-1:0]                      resp_data_i
);
  import dcache_pkg::*;

  logic              any_req;
  logic [PORT_W-1:0] pick;
  // port locked while its request waits for accept
  logic              lock_q;
  logic [PORT_W-1:0] lock_port_q;

  // lowest requesting port, scanned from the top so port 0 wins
  always_comb begin
    pick    = '0;
    any_req = 1'b0;
    for (int p = NUM_PORTS - 1; p >= 0; p--) begin
      if (req_i[p]) begin
        pick    = PORT_W'(p);
        any_req = 1'b1;
      end
    end
  end

  assign sel_port_o  = lock_q ? lock_port_q : pick;
  // a locked port is still requesting, it holds req until gnt
  assign sel_req_o   = lock_q | any_req;
  assign sel_we_o    = we_i[sel_port_o];
  assign sel_addr_o  = addr_i[sel_port_o];
  assign sel_wdata_o = wdata_i[sel_port_o];
  assign sel_be_o    = be_i[sel_port_o];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q      <= 1'b0;
      lock_port_q <= '0;
    end else if (accept_i) begin
      lock_q <= 1'b0;
    end else if (sel_req_o) begin
      // controller busy or flushing, keep this choice
      lock_q      <= 1'b1;
      lock_port_q <= sel_port_o;
    end
  end

  // ----------------------------------------
  // grant and response routing
  // ----------------------------------------
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      gnt_o[p]    = accept_i && (sel_port_o == PORT_W'(p));
      rvalid_o[p] = resp_valid_i && (resp_port_i == PORT_W'(p));
      // data only shows on the port that owns the response
      rdata_o[p]  = rvalid_o[p] ? resp_data_i : '0;
    end
  end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
/*
  Data cache subsystem top: three request ports, port 0 highest priority.
  Memory side is Wishbone classic, one word per cycle.
*/
`default_nettype none

module dcache_top (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  logic                                               enable_i,
  input  logic                                               flush_i,
  output logic                                               flush_ack_o,
  output logic                                               miss_o,
  // request ports, 0 page walker, 1 load, 2 store
  input  logic [dcache_pkg::NUM_PORTS-1:0]                   req_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0]                   we_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::DATA_W-1:0] wdata_i,
  input  logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::BE_W-1:0]   be_i,
  output logic [dcache_pkg::NUM_PORTS-1:0]                   gnt_o,
  output logic [dcache_pkg::NUM_PORTS-1:0]                   rvalid_o,
  output logic [dcache_pkg::NUM_PORTS-1:0][dcache_pkg::DATA_W-1:0] rdata_o,
  // Wishbone classic master
  output logic                                               wb_cyc_o,
  output logic                                               wb_stb_o,
  output logic                                               wb_we_o,
  output logic [dcache_pkg::ADDR_W-1:0]                      wb_adr_o,
  output logic [dcache_pkg::DATA_W-1:0]                      wb_dat_o,
  output logic [dcache_pkg::BE_W-1:0]                        wb_sel_o,
  input  logic [dcache_pkg::DATA_W-1:0]                      wb_dat_i,
  input  logic                                               wb_ack_i
);
  import dcache_pkg::*;

  // arbiter to controller
  logic              sel_req;
  logic              sel_we;
  logic [ADDR_W-1:0] sel_addr;
  logic [DATA_W-1:0] sel_wdata;
  logic [BE_W-1:0]   sel_be;
  logic [PORT_W-1:0] sel_port;
  logic              accept;
  logic              resp_valid;
  logic [PORT_W-1:0] resp_port;
  logic [DATA_W-1:0] resp_data;

  // controller to bus master
  logic              mem_req;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [BE_W-1:0]   mem_be;
  logic              mem_done;
  logic [DATA_W-1:0] mem_rdata;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  dcache_port_arbiter dcache_port_arbiter_i (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .sel_req_o    (sel_req),
    .sel_we_o     (sel_we),
    .sel_addr_o   (sel_addr),
    .sel_wdata_o  (sel_wdata),
    .sel_be_o     (sel_be),
    .sel_port_o   (sel_port),
    .accept_i     (accept),
    .resp_valid_i (resp_valid),
    .resp_port_i  (resp_port),
    .resp_data_i  (resp_data)
  );

  // ----------------------------------------
  // cache controller
  // ----------------------------------------
  dcache_ctrl dcache_ctrl_i (
    .clk_i,
    .arst_n_i,
    .enable_i,
    .flush_i,
    .flush_ack_o,
    .miss_o,
    .sel_req_i    (sel_req),
    .sel_we_i     (sel_we),
    .sel_addr_i   (sel_addr),
    .sel_wdata_i  (sel_wdata),
    .sel_be_i     (sel_be),
    .sel_port_i   (sel_port),
    .accept_o     (accept),
    .resp_valid_o (resp_valid),
    .resp_port_o  (resp_port),
    .resp_data_o  (resp_data),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .mem_done_i   (mem_done),
    .mem_rdata_i  (mem_rdata)
  );

  // ----------------------------------------
  // memory side
  // ----------------------------------------
  dcache_mem_if dcache_mem_if_i (
    .clk_i,
    .arst_n_i,
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_be_i    (mem_be),
    .mem_done_o  (mem_done),
    .mem_rdata_o (mem_rdata),
    .wb_cyc_o,
    .wb_stb_o,
    .wb_we_o,
    .wb_adr_o,
    .wb_dat_o,
    .wb_sel_o,
    .wb_dat_i,
    .wb_ack_i
  );

endmodule

`default_nettype wire
